/* verilog/convTypesPkg.sv */
package convTypesPkg;

    // Pixel and coefficient width
    localparam int PIXEL_W = 8;
    // Window is WIN_N columns by WIN_N rows
    localparam int WIN_N = 3;
    // Nine 8x8 products fit in 20 bits
    localparam int ACC_W = 20;
    // Result keeps bits 19 down to 7, so the kernel scale is 128
    localparam int RES_LSB = 7;
    localparam int RES_W = ACC_W - RES_LSB;
    // Up to 1024 image columns
    localparam int ADDR_W = 10;
    localparam int IMG_DEPTH = 1 << ADDR_W;
    // Cycles from an input column to its result strobe
    localparam int MAC_LATENCY = 3;

    // Image column: p0 is row 0 in the top byte
    // As a kernel row, pN is the coefficient at window column N
    typedef struct packed {
        logic [PIXEL_W-1:0] p0;
        logic [PIXEL_W-1:0] p1;
        logic [PIXEL_W-1:0] p2;
    } pixelCol_t;

    typedef struct packed {
        pixelCol_t row0;
        pixelCol_t row1;
        pixelCol_t row2;
    } kernel_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [RES_W-1:0]  value;
    } convResult_t;

endpackage

/* verilog/hostCmdPkg.sv */
package hostCmdPkg;

    // Opcode field of the GPIO port
    localparam int OP_W = 3;

    localparam logic [OP_W-1:0] OP_KERNEL_LOAD = 3'd0;
    localparam logic [OP_W-1:0] OP_SIZE_LOAD   = 3'd1;
    localparam logic [OP_W-1:0] OP_IMG_LOAD    = 3'd2;
    localparam logic [OP_W-1:0] OP_DATA_REQ    = 3'd3;
    localparam logic [OP_W-1:0] OP_RUN         = 3'd4;
    // Codes 5 to 7 have no effect

    localparam int HOST_DATA_W = 24;
    localparam int HOST_READ_W = 32;
    // End-of-process flag in the readback word
    localparam int EOP_BIT = 31;

    // Decoded command, strobe is high for one cycle per valid edge
    typedef struct packed {
        logic [OP_W-1:0]        op;
        logic [HOST_DATA_W-1:0] data;
        logic                   strobe;
    } hostCmd_t;

endpackage

/* verilog/sampleBuffer.sv */
`timescale 1ns/100ps

module sampleBuffer #(
    parameter int  DEPTH = 1024,
    parameter type payload_t = logic [7:0]
) (
    input  logic                     i_CLK,
    input  logic                     i_writeEnable,
    input  logic [$clog2(DEPTH)-1:0] i_writeAddr,
    input  payload_t                 i_writeData,
    input  logic                     i_readEnable,
    input  logic [$clog2(DEPTH)-1:0] i_readAddr,
    output payload_t                 o_readData
);

    // Inferred block RAM
    payload_t mem [DEPTH];

    always_ff @(posedge i_CLK) begin
        if (i_writeEnable) begin
            mem[i_writeAddr] <= i_writeData;
        end
        // Registered read, old data on a same-address write
        if (i_readEnable) begin
            o_readData <= mem[i_readAddr];
        end
    end

endmodule

/* verilog/columnCounter.sv */
`timescale 1ns/100ps

module columnCounter (
    input  logic                            i_CLK,
    input  logic                            i_rst,
    input  logic                            i_clear,
    input  logic                            i_enable,
    input  logic [convTypesPkg::ADDR_W-1:0] i_lastValue,
    output logic [convTypesPkg::ADDR_W-1:0] o_addr,
    output logic                            o_last
);
    import convTypesPkg::*;

    // Clear wins over enable
    always_ff @(posedge i_CLK) begin
        if (i_rst || i_clear) begin
            o_addr <= '0;
        end else if (i_enable) begin
            o_addr <= o_addr + ADDR_W'(1);
        end
    end

    // High while the current address is the final column
    assign o_last = (o_addr == i_lastValue);

endmodule

/* verilog/convMac.sv */
`timescale 1ns/100ps

module convMac (
    input  logic                      i_CLK,
    input  logic                      i_rst,
    input  logic                      i_clear,
    input  logic                      i_enable,
    input  convTypesPkg::pixelCol_t   i_column,
    input  convTypesPkg::kernel_t     i_kernel,
    output convTypesPkg::convResult_t o_result,
    output logic                      o_resultValid
);
    import convTypesPkg::*;

    // Window columns 0 and 1, the incoming column is column 2
    pixelCol_t winOld;
    pixelCol_t winMid;
    logic [WIN_N-1:0][WIN_N-1:0][PIXEL_W-1:0] windowArr;
    logic [WIN_N-1:0][WIN_N-1:0][PIXEL_W-1:0] kernelArr;
    // Index of the incoming column since the clear
    logic [ADDR_W-1:0]    colIdx;
    logic [2*PIXEL_W-1:0] prod [WIN_N][WIN_N];
    logic [ACC_W-1:0]     rowSumD [WIN_N];
    logic [ACC_W-1:0]     rowSum [WIN_N];
    logic [ACC_W-1:0]     total;
    logic [1:0]           stageValid;
    logic [ADDR_W-1:0]    stageAddr [2];

    assign windowArr = {winOld, winMid, i_column};
    assign kernelArr = i_kernel;

    always_ff @(posedge i_CLK) begin
        if (i_rst || i_clear) begin
            colIdx        <= '0;
            stageValid    <= '0;
            o_resultValid <= 1'b0;
        end else begin
            if (i_enable) begin
                colIdx <= colIdx + ADDR_W'(1);
            end
            // Window is full from the third column on
            stageValid    <= {stageValid[0], i_enable && (colIdx >= ADDR_W'(WIN_N - 1))};
            o_resultValid <= stageValid[1];
        end
    end

    // Datapath, one stage per clock
    always_ff @(posedge i_CLK) begin
        if (i_enable) begin
            winOld <= winMid;
            winMid <= i_column;
        end
        // Both arrays index top-first, so [r][c] and [c][r] meet
        for (int r = 0; r < WIN_N; r++) begin
            for (int c = 0; c < WIN_N; c++) begin
                prod[r][c] <= kernelArr[r][c] * windowArr[c][r];
            end
        end
        stageAddr[0] <= colIdx - ADDR_W'(WIN_N - 1);
        rowSum       <= rowSumD;
        stageAddr[1] <= stageAddr[0];
        o_result.value <= total[ACC_W-1:RES_LSB];
        o_result.addr  <= stageAddr[1];
    end

    always_comb begin
        total = '0;
        for (int r = 0; r < WIN_N; r++) begin
            rowSumD[r] = '0;
            for (int c = 0; c < WIN_N; c++) begin
                rowSumD[r] += ACC_W'(prod[r][c]);
            end
            // Stage 3 adds the registered row sums
            total += rowSum[r];
        end
    end

endmodule

/* verilog/convSequencer.sv */
`timescale 1ns/100ps

module convSequencer (
    input  logic                 i_CLK,
    input  logic                 i_rst,
    input  hostCmdPkg::hostCmd_t i_cmd,
    input  logic                 i_lastCol,
    output logic                 o_cntClear,
    output logic                 o_cntEnable,
    output logic                 o_imgWrite,
    output logic                 o_imgRead,
    output logic                 o_resRead,
    output logic                 o_macEnable,
    output logic                 o_macClear,
    output logic                 o_running,
    output logic                 o_eop
);
    import convTypesPkg::*;
    import hostCmdPkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOADING,
        RUNNING,
        DRAIN,
        DONE
    } seqState_t;

    seqState_t state;
    logic [$clog2(MAC_LATENCY+1)-1:0] drainCnt;
    logic acceptCmd;

    assign o_running = (state == RUNNING) || (state == DRAIN);
    assign o_eop     = (state == DONE);
    // Host commands outside the run phase
    assign acceptCmd = i_cmd.strobe && !o_running;

    always_ff @(posedge i_CLK) begin
        if (i_rst) begin
            state       <= IDLE;
            drainCnt    <= '0;
            o_cntClear  <= 1'b0;
            o_cntEnable <= 1'b0;
            o_imgWrite  <= 1'b0;
            o_imgRead   <= 1'b0;
            o_resRead   <= 1'b0;
            o_macEnable <= 1'b0;
            o_macClear  <= 1'b0;
        end else begin
            // Single-cycle pulses by default
            o_cntClear  <= 1'b0;
            o_cntEnable <= 1'b0;
            o_imgWrite  <= 1'b0;
            o_imgRead   <= 1'b0;
            o_macClear  <= 1'b0;
            // Readback is served in every state
            o_resRead   <= i_cmd.strobe && (i_cmd.op == OP_DATA_REQ);
            // Image RAM read data arrives one cycle after the read
            o_macEnable <= o_imgRead;
            case (state)
                RUNNING: begin
                    // Last column already requested
                    if (o_imgRead && i_lastCol) begin
                        drainCnt <= '0;
                        state    <= DRAIN;
                    end else begin
                        o_imgRead   <= 1'b1;
                        o_cntEnable <= 1'b1;
                    end
                end
                DRAIN: begin
                    // Let the MAC pipeline empty
                    if (drainCnt == MAC_LATENCY) begin
                        state <= DONE;
                    end else begin
                        drainCnt <= drainCnt + 1'b1;
                    end
                end
                default: begin
                    if (acceptCmd) begin
                        case (i_cmd.op)
                            OP_KERNEL_LOAD: state <= IDLE;
                            OP_SIZE_LOAD: begin
                                o_cntClear <= 1'b1;
                                state      <= LOADING;
                            end
                            // Write at the current address, then advance
                            OP_IMG_LOAD: begin
                                o_imgWrite  <= 1'b1;
                                o_cntEnable <= 1'b1;
                                state       <= LOADING;
                            end
                            // A finished run waits for a load first
                            OP_RUN: begin
                                if (state != DONE) begin
                                    o_cntClear <= 1'b1;
                                    o_macClear <= 1'b1;
                                    state      <= RUNNING;
                                end
                            end
                            default: begin
                            end
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

/* verilog/hostCommandDecoder.sv */
`timescale 1ns/100ps

module hostCommandDecoder (
    input  logic                               i_CLK,
    input  logic                               i_rst,
    input  logic [hostCmdPkg::HOST_DATA_W-1:0] i_hostData,
    input  logic [hostCmdPkg::OP_W-1:0]        i_hostOp,
    input  logic                               i_hostValid,
    input  logic                               i_running,
    input  logic                               i_eop,
    input  convTypesPkg::convResult_t          i_resRead,
    output hostCmdPkg::hostCmd_t               o_cmd,
    output convTypesPkg::kernel_t              o_kernel,
    output logic [convTypesPkg::ADDR_W-1:0]    o_imgLength,
    output logic [hostCmdPkg::HOST_READ_W-1:0] o_hostRead
);
    import convTypesPkg::*;
    import hostCmdPkg::*;

    // Port sampled once
    logic [HOST_DATA_W-1:0] dataQ;
    logic [OP_W-1:0]        opQ;
    logic                   validQ;
    logic                   validPrev;
    logic                   validEdge;
    // Data request strobe delayed to meet the registered RAM read
    logic [1:0]             reqDelay;
    logic [RES_W-1:0]       resValue;

    // Only a rising level counts, holding valid high does not repeat
    assign validEdge = validQ && !validPrev;

    always_ff @(posedge i_CLK) begin
        if (i_rst) begin
            opQ         <= '0;
            validQ      <= 1'b0;
            validPrev   <= 1'b0;
            o_cmd       <= '0;
            o_kernel    <= '0;
            o_imgLength <= '0;
            reqDelay    <= '0;
            resValue    <= '0;
        end else begin
            opQ          <= i_hostOp;
            validQ       <= i_hostValid;
            validPrev    <= validQ;
            o_cmd.strobe <= validEdge;
            // Op and data held until the next command
            if (validEdge) begin
                o_cmd.op   <= opQ;
                o_cmd.data <= dataQ;
            end
            // Loads are dropped while the engine runs
            if (validEdge && !i_running) begin
                case (opQ)
                    // Rows move up, new row enters row 2
                    OP_KERNEL_LOAD: begin
                        o_kernel <= {o_kernel.row1, o_kernel.row2, pixelCol_t'(dataQ)};
                    end
                    OP_SIZE_LOAD: begin
                        o_imgLength <= dataQ[ADDR_W-1:0];
                    end
                    default: begin
                    end
                endcase
            end
            reqDelay <= {reqDelay[0], o_cmd.strobe && (o_cmd.op == OP_DATA_REQ)};
            // Result buffer output is valid here
            if (reqDelay[1]) begin
                resValue <= i_resRead.value;
            end
        end
    end

    // Payload register
    always_ff @(posedge i_CLK) begin
        dataQ <= i_hostData;
    end

    // Readback word: EOP on top, result in the low bits
    always_comb begin
        o_hostRead = '0;
        o_hostRead[EOP_BIT] = i_eop;
        o_hostRead[RES_W-1:0] = resValue;
    end

endmodule

/* verilog/convTop.sv */
`timescale 1ns/100ps

module convTop (
    input  logic                               i_CLK,
    input  logic                               i_rst,
    input  logic [hostCmdPkg::HOST_DATA_W-1:0] i_hostData,
    input  logic [hostCmdPkg::OP_W-1:0]        i_hostOp,
    input  logic                               i_hostValid,
    output logic [hostCmdPkg::HOST_READ_W-1:0] o_hostRead
);
    import convTypesPkg::*;
    import hostCmdPkg::*;

    hostCmd_t          cmd;
    kernel_t           kernel;
    logic [ADDR_W-1:0] imgLength;
    logic [ADDR_W-1:0] colAddr;
    logic              lastCol;
    logic              cntClear;
    logic              cntEnable;
    logic              imgWrite;
    logic              imgRead;
    logic              resRead;
    logic              macEnable;
    logic              macClear;
    logic              running;
    logic              eop;
    pixelCol_t         imgColumn;
    convResult_t       macResult;
    logic              macValid;
    convResult_t       resReadData;

    hostCommandDecoder u_decoder (
        .i_CLK       (i_CLK),
        .i_rst       (i_rst),
        .i_hostData  (i_hostData),
        .i_hostOp    (i_hostOp),
        .i_hostValid (i_hostValid),
        .i_running   (running),
        .i_eop       (eop),
        .i_resRead   (resReadData),
        .o_cmd       (cmd),
        .o_kernel    (kernel),
        .o_imgLength (imgLength),
        .o_hostRead  (o_hostRead)
    );

    convSequencer u_seq (
        .i_CLK       (i_CLK),
        .i_rst       (i_rst),
        .i_cmd       (cmd),
        .i_lastCol   (lastCol),
        .o_cntClear  (cntClear),
        .o_cntEnable (cntEnable),
        .o_imgWrite  (imgWrite),
        .o_imgRead   (imgRead),
        .o_resRead   (resRead),
        .o_macEnable (macEnable),
        .o_macClear  (macClear),
        .o_running   (running),
        .o_eop       (eop)
    );

    // Last column is length minus one
    columnCounter u_counter (
        .i_CLK       (i_CLK),
        .i_rst       (i_rst),
        .i_clear     (cntClear),
        .i_enable    (cntEnable),
        .i_lastValue (imgLength - ADDR_W'(1)),
        .o_addr      (colAddr),
        .o_last      (lastCol)
    );

    // Loaded from the command data and read back during the run
    sampleBuffer #(
        .DEPTH     (IMG_DEPTH),
        .payload_t (pixelCol_t)
    ) u_imgBuf (
        .i_CLK         (i_CLK),
        .i_writeEnable (imgWrite),
        .i_writeAddr   (colAddr),
        .i_writeData   (pixelCol_t'(cmd.data)),
        .i_readEnable  (imgRead),
        .i_readAddr    (colAddr),
        .o_readData    (imgColumn)
    );

    convMac u_mac (
        .i_CLK         (i_CLK),
        .i_rst         (i_rst),
        .i_clear       (macClear),
        .i_enable      (macEnable),
        .i_column      (imgColumn),
        .i_kernel      (kernel),
        .o_result      (macResult),
        .o_resultValid (macValid)
    );

    // Readback address comes straight from the request data
    sampleBuffer #(
        .DEPTH     (IMG_DEPTH),
        .payload_t (convResult_t)
    ) u_resBuf (
        .i_CLK         (i_CLK),
        .i_writeEnable (macValid),
        .i_writeAddr   (macResult.addr),
        .i_writeData   (macResult),
        .i_readEnable  (resRead),
        .i_readAddr    (cmd.data[ADDR_W-1:0]),
        .o_readData    (resReadData)
    );

endmodule

/* testbench/convChecker.sv */
`timescale 1ns/100ps

module convChecker (
    input  logic                               i_CLK,
    input  logic [hostCmdPkg::HOST_READ_W-1:0] i_hostRead,
    input  logic                               i_valueStrobe,
    input  logic [hostCmdPkg::HOST_READ_W-1:0] i_expectWord,
    input  logic                               i_eopStrobe,
    input  logic                               i_eopExpect,
    input  logic                               i_testDone,
    input  int                                 i_testIdx,
    input  logic                               i_finalReport,
    output int                                 o_errorCount
);
    import hostCmdPkg::*;

    // Totals over the whole run
    int checkCount = 0;
    int errorCount = 0;
    int testsDone = 0;
    // Counts for the test in progress
    int testChecks = 0;
    int testErrors = 0;

    assign o_errorCount = errorCount;

    // Strobes come from the stimulus on one edge and are sampled on the next
    always @(posedge i_CLK) begin
        // Whole readback word, EOP included
        if (i_valueStrobe) begin
            checkCount++;
            testChecks++;
            if (i_hostRead !== i_expectWord) begin
                $display("Mismatch o_hostRead: got %h, expected %h", i_hostRead, i_expectWord);
                errorCount++;
                testErrors++;
            end
        end
        // EOP flag on its own
        if (i_eopStrobe) begin
            checkCount++;
            testChecks++;
            if (i_hostRead[EOP_BIT] !== i_eopExpect) begin
                if (i_eopExpect) begin
                    $display("End-of-process did not rise after the run was started");
                end else begin
                    $display("End-of-process is still set after a new kernel load");
                end
                errorCount++;
                testErrors++;
            end
        end
        if (i_testDone) begin
            $display("Test %0d finished: %0d checks, %0d errors",
                     i_testIdx, testChecks, testErrors);
            testsDone++;
            testChecks = 0;
            testErrors = 0;
        end
        // Closing count line
        if (i_finalReport) begin
            $display("Summary: %0d tests, %0d checks, %0d errors",
                     testsDone, checkCount, errorCount);
        end
    end

endmodule

/* testbench/convTb.sv */
`timescale 1ns/100ps

module convTb;
    import convTypesPkg::*;
    import hostCmdPkg::*;

    localparam int NUM_TESTS = 5;
    localparam int SHORT_HOLD = 2;
    localparam int LONG_HOLD = 10;

    // One table row: kernel rows top first, image length, long valid pulses
    typedef struct packed {
        pixelCol_t         row0;
        pixelCol_t         row1;
        pixelCol_t         row2;
        logic [ADDR_W-1:0] length;
        logic              longHold;
    } testVec_t;

    logic                   clk;
    logic                   rst;
    logic [HOST_DATA_W-1:0] hostData;
    logic [OP_W-1:0]        hostOp;
    logic                   hostValid;
    logic [HOST_READ_W-1:0] hostRead;
    // Checker strobes
    logic                   valueStrobe;
    logic [HOST_READ_W-1:0] expectWord;
    logic                   eopStrobe;
    logic                   eopExpect;
    logic                   testDone;
    int                     testIdx;
    logic                   finalReport;
    int                     errorCount;

    testVec_t          tests [NUM_TESTS];
    pixelCol_t         imgCols [IMG_DEPTH];
    logic [RES_W-1:0]  expRes [IMG_DEPTH];
    logic              expValid [IMG_DEPTH];
    logic [31:0]       rngState = 32'h5a0af4e3;
    int                cycleCount = 0;
    int                timeoutLimit;

    convTop u_dut (
        .i_CLK       (clk),
        .i_rst       (rst),
        .i_hostData  (hostData),
        .i_hostOp    (hostOp),
        .i_hostValid (hostValid),
        .o_hostRead  (hostRead)
    );

    convChecker u_checker (
        .i_CLK         (clk),
        .i_hostRead    (hostRead),
        .i_valueStrobe (valueStrobe),
        .i_expectWord  (expectWord),
        .i_eopStrobe   (eopStrobe),
        .i_eopExpect   (eopExpect),
        .i_testDone    (testDone),
        .i_testIdx     (testIdx),
        .i_finalReport (finalReport),
        .o_errorCount  (errorCount)
    );

    // 40 ns clock
    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Run limit from the test lengths
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout after %0d cycles, the DUT never finished the tests", cycleCount);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcgStep(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Upper 24 bits of the next LCG state
    task automatic drawColumn(output pixelCol_t col);
        rngState = lcgStep(rngState);
        col = pixelCol_t'(rngState[31:8]);
    endtask

    task automatic setTest(input int idx, input pixelCol_t r0, input pixelCol_t r1,
                           input pixelCol_t r2, input int len, input logic longHold);
        tests[idx].row0     = r0;
        tests[idx].row1     = r1;
        tests[idx].row2     = r2;
        tests[idx].length   = ADDR_W'(len);
        tests[idx].longHold = longHold;
    endtask

    // Sum over window column c and row r of coef[r][c] * pixel[j+c][r], bits 19 to 7
    function automatic logic [RES_W-1:0] modelResult(input testVec_t tv, input int j);
        logic [ACC_W-1:0] acc;
        pixelCol_t        kRow;
        acc = '0;
        for (int r = 0; r < WIN_N; r++) begin
            kRow = (r == 0) ? tv.row0 : ((r == 1) ? tv.row1 : tv.row2);
            for (int c = 0; c < WIN_N; c++) begin
                // Byte c of a row and row r of a column, both counted from the top byte
                acc += kRow[(2-c)*PIXEL_W +: PIXEL_W] * imgCols[j+c][(2-r)*PIXEL_W +: PIXEL_W];
            end
        end
        return acc[ACC_W-1:RES_LSB];
    endfunction

    // EOP on top, result value in the low bits
    function automatic logic [HOST_READ_W-1:0] readbackWord(input logic [RES_W-1:0] value);
        logic [HOST_READ_W-1:0] word;
        word = '0;
        word[EOP_BIT] = 1'b1;
        word[RES_W-1:0] = value;
        return word;
    endfunction

    // Called on a rising edge; valid high for holdCycles then low for 2 cycles
    task automatic sendCommand(input logic [OP_W-1:0] op, input logic [HOST_DATA_W-1:0] data,
                               input int holdCycles);
        hostOp    <= op;
        hostData  <= data;
        hostValid <= 1'b1;
        repeat (holdCycles) @(posedge clk);
        hostValid <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // Readback is ready 4 cycles after the edge is sampled
    task automatic requestResult(input int addr, input logic [HOST_READ_W-1:0] expected,
                                 input int holdCycles);
        int steps;
        steps = (holdCycles + 2 > 6) ? holdCycles + 2 : 6;
        hostOp    <= OP_DATA_REQ;
        hostData  <= HOST_DATA_W'(addr);
        hostValid <= 1'b1;
        for (int k = 1; k <= steps; k++) begin
            @(posedge clk);
            if (k == holdCycles) begin
                hostValid <= 1'b0;
            end
            // Edge sampled at k = 1, checker samples on the edge after k = 5
            if (k == 5) begin
                valueStrobe <= 1'b1;
                expectWord  <= expected;
            end else begin
                valueStrobe <= 1'b0;
            end
        end
    endtask

    task automatic checkEop(input logic expected);
        eopExpect <= expected;
        eopStrobe <= 1'b1;
        @(posedge clk);
        eopStrobe <= 1'b0;
    endtask

    // Run command, then wait for EOP with a local limit
    task automatic runAndWait(input int holdCycles, input int len);
        int waited;
        waited = 0;
        sendCommand(OP_RUN, '0, holdCycles);
        while (!hostRead[EOP_BIT] && waited < len * 4 + 64) begin
            @(posedge clk);
            waited++;
        end
        checkEop(1'b1);
    endtask

    task automatic runTest(input int t);
        testVec_t tv;
        int       hold;
        int       len;
        tv = tests[t];
        len = int'(tv.length);
        hold = tv.longHold ? LONG_HOLD : SHORT_HOLD;
        // First row load also clears a previous EOP
        sendCommand(OP_KERNEL_LOAD, tv.row0, hold);
        checkEop(1'b0);
        sendCommand(OP_KERNEL_LOAD, tv.row1, hold);
        sendCommand(OP_KERNEL_LOAD, tv.row2, hold);
        sendCommand(OP_SIZE_LOAD, HOST_DATA_W'(len), hold);
        for (int i = 0; i < len; i++) begin
            drawColumn(imgCols[i]);
            sendCommand(OP_IMG_LOAD, imgCols[i], hold);
        end
        runAndWait(hold, len);
        // L minus 2 results at addresses 0 to L minus 3
        for (int j = 0; j < len - 2; j++) begin
            expRes[j] = modelResult(tv, j);
            expValid[j] = 1'b1;
            requestResult(j, readbackWord(expRes[j]), hold);
        end
        // Next address must still hold an older run's result
        if (expValid[len-2]) begin
            requestResult(len - 2, readbackWord(expRes[len-2]), hold);
        end
        testIdx  <= t;
        testDone <= 1'b1;
        @(posedge clk);
        testDone <= 1'b0;
    endtask

    initial begin
        pixelCol_t k0;
        pixelCol_t k1;
        pixelCol_t k2;
        // All DUT inputs and checker strobes
        rst         = 1'b1;
        hostData    = '0;
        hostOp      = '0;
        hostValid   = 1'b0;
        valueStrobe = 1'b0;
        expectWord  = '0;
        eopStrobe   = 1'b0;
        eopExpect   = 1'b0;
        testDone    = 1'b0;
        testIdx     = 0;
        finalReport = 1'b0;
        for (int a = 0; a < IMG_DEPTH; a++) begin
            expValid[a] = 1'b0;
        end
        // Centre-only kernel of 128 passes row 1 through
        setTest(0, 24'h000000, 24'h008000, 24'h000000, 8, 1'b0);
        setTest(1, '0, '0, '0, 8, 1'b0);
        setTest(2, '0, '0, '0, 40, 1'b0);
        setTest(3, '0, '0, '0, 3, 1'b0);
        setTest(4, '0, '0, '0, 12, 1'b1);
        for (int t = 1; t < NUM_TESTS; t++) begin
            drawColumn(k0);
            drawColumn(k1);
            drawColumn(k2);
            tests[t].row0 = k0;
            tests[t].row1 = k1;
            tests[t].row2 = k2;
        end
        timeoutLimit = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            timeoutLimit += int'(tests[t].length) * 32 + 200;
        end
        timeoutLimit *= 2;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // Readback is all zero after reset
        valueStrobe <= 1'b1;
        expectWord  <= '0;
        @(posedge clk);
        valueStrobe <= 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        finalReport <= 1'b1;
        @(posedge clk);
        finalReport <= 1'b0;
        @(posedge clk);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/convTypesPkg.sv
verilog/hostCmdPkg.sv
verilog/sampleBuffer.sv
verilog/columnCounter.sv
verilog/convMac.sv
verilog/convSequencer.sv
verilog/hostCommandDecoder.sv
verilog/convTop.sv
testbench/convChecker.sv
testbench/convTb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing -Wno-fatal --top-module convTb -f project.f -o convSim \
    && ./obj_dir/convSim | tee /dev/stderr | grep "TEST PASSED" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
